/* logic/sm_settings.svh */
`ifndef SM_SETTINGS_SVH
`define SM_SETTINGS_SVH

// read address with the bank in bit 9
`define SM_ADDR_W 10

// one instruction or data word
`define SM_WORD_W 18

// write ports load half words
`define SM_HALF_W 9

// instruction fields
// opcode sits on top of the operand
`define SM_OP_W 3
`define SM_ARG_W 15

// host register data
`define SM_REG_W 16

`endif

/* logic/smPkg.sv */
`default_nettype none
`include "sm_settings.svh"

package smPkg;

	// ------------------------------
	// plain vectors
	// ------------------------------
	// read address or program counter
	typedef logic [`SM_ADDR_W-1:0] smAddr_t;
	// half word index, bit 0 selects the half
	typedef logic [`SM_ADDR_W-1:0] smWAddr_t;
	typedef logic [`SM_WORD_W-1:0] smWord_t;
	typedef logic [`SM_HALF_W-1:0] smHalf_t;
	typedef logic [`SM_ARG_W-1:0]  smArg_t;
	typedef logic [`SM_REG_W-1:0]  smReg_t;

	// ------------------------------
	// encodings
	// ------------------------------
	// unlisted codes run as nop
	typedef enum logic [`SM_OP_W-1:0] {
		OpNop  = 3'd0,
		OpEmit = 3'd1,
		OpJump = 3'd2,
		OpWait = 3'd3,
		OpHalt = 3'd7
	} smOp_e;

	typedef enum logic [1:0] {
		SeqIdle,
		SeqFetch,
		SeqExec,
		SeqWait
	} smSeqState_e;

	// ------------------------------
	// bundles
	// ------------------------------
	// registers to sequencer
	typedef struct packed {
		smAddr_t startPc;
		logic    start;
		logic    abort;
	} smCtrl_t;

	// event leaving the sequencer
	typedef struct packed {
		logic   valid;
		smArg_t arg;
	} smEvent_t;

	// one half-word write port
	typedef struct packed {
		logic     sel;
		smWAddr_t addr;
		smHalf_t  data;
	} smWrite_t;

endpackage

`default_nettype wire

/* logic/smBankRam.sv */
`default_nettype none
`include "sm_settings.svh"

module smBankRam import smPkg::*; (
	input  wire                   ReadClockIn,

	// half-word write side
	input  wire                   writeSel_i,
	input  wire smWAddr_t         writeAddr_i,
	input  wire smHalf_t          writeData_i,

	// full-word read side
	input  wire                   readSel_i,
	input  wire [`SM_ADDR_W-2:0]  readWord_i,
	output smWord_t               readData_o
);

	// 512 words per bank
	localparam int Depth = 1 << (`SM_ADDR_W - 1);

	smWord_t mem [Depth];

	logic [`SM_ADDR_W-2:0] writeWord;
	logic                  writeHigh;

	// bits 9..1 give the word
	assign writeWord = writeAddr_i[`SM_ADDR_W-1:1];
	// odd address is the upper half
	assign writeHigh = writeAddr_i[0];

	// ------------------------------
	// write
	// ------------------------------
	always_ff @(posedge ReadClockIn) begin
		if (writeSel_i) begin
			if (writeHigh) begin
				mem[writeWord][`SM_WORD_W-1:`SM_HALF_W] <= writeData_i;
			end else begin
				mem[writeWord][`SM_HALF_W-1:0] <= writeData_i;
			end
		end
	end

	// ------------------------------
	// read, one cycle latency
	// ------------------------------
	// output holds until the next strobe
	always_ff @(posedge ReadClockIn) begin
		if (readSel_i) begin
			readData_o <= mem[readWord_i];
		end
	end

endmodule

`default_nettype wire

/* logic/smMemory.sv */
`default_nettype none
`include "sm_settings.svh"

module smMemory import smPkg::*; (
	input  wire                  ReadClockIn,
	input  wire                  reset_i,

	// sequencer side
	input  wire                  busy_i,
	input  wire smAddr_t         fetchAddr_i,
	input  wire                  fetchSel_i,

	// host side
	input  wire smAddr_t         hostReadAddr_i,
	input  wire                  hostReadSel_i,
	input  wire smWrite_t        loadWrite_i,
	input  wire smWrite_t        dataWrite_i,

	// bank connections
	input  wire smWord_t         bank0Data_i,
	input  wire smWord_t         bank1Data_i,
	output logic                 bank0ReadSel_o,
	output logic                 bank1ReadSel_o,
	output logic [`SM_ADDR_W-2:0] readWord_o,
	output smWrite_t             bank0Write_o,
	output smWrite_t             bank1Write_o,

	// returned word
	output smWord_t              readData_o,
	output logic                 hostReadValid_o
);

	smAddr_t readAddr;
	logic    readSel;
	logic    bankSelQ;
	logic    bankSel;

	// ------------------------------
	// read source
	// ------------------------------
	// sequencer owns the port while busy
	// host strobes are dropped then
	assign readAddr = busy_i ? fetchAddr_i : hostReadAddr_i;
	assign readSel  = busy_i ? fetchSel_i : hostReadSel_i;

	// split strobe per bank on bit 9
	assign bank0ReadSel_o = readSel && !readAddr[`SM_ADDR_W-1];
	assign bank1ReadSel_o = readSel && readAddr[`SM_ADDR_W-1];
	assign readWord_o     = readAddr[`SM_ADDR_W-2:0];

	// ------------------------------
	// bank select
	// ------------------------------
	// registered copy lines up with ram output
	always_ff @(posedge ReadClockIn) begin
		if (reset_i) begin
			bankSelQ <= 1'b0;
		end else if (readSel) begin
			bankSelQ <= readAddr[`SM_ADDR_W-1];
		end
	end

	// fetch address is held steady, so live bit works while busy
	assign bankSel    = busy_i ? readAddr[`SM_ADDR_W-1] : bankSelQ;
	assign readData_o = bankSel ? bank1Data_i : bank0Data_i;

	// host read answers one cycle later
	always_ff @(posedge ReadClockIn) begin
		if (reset_i) begin
			hostReadValid_o <= 1'b0;
		end else begin
			hostReadValid_o <= hostReadSel_i && !busy_i;
		end
	end

	// load port fills code bank, data port the mailbox bank
	assign bank0Write_o = loadWrite_i;
	assign bank1Write_o = dataWrite_i;

endmodule

`default_nettype wire

/* logic/smSequencer.sv */
`default_nettype none
`include "sm_settings.svh"

module smSequencer import smPkg::*; (
	input  wire           ReadClockIn,
	input  wire           reset_i,

	// from the register block
	input  wire smCtrl_t  ctrl_i,

	// instruction fetch
	input  wire smWord_t  fetchData_i,
	output smAddr_t       fetchAddr_o,
	output logic          fetchSel_o,
	output logic          busy_o,

	// emitted event
	output smEvent_t      event_o
);

	smSeqState_e state;
	smAddr_t     pc;
	smArg_t      waitCnt;
	smOp_e       op;
	smArg_t      arg;

	// ------------------------------
	// decode
	// ------------------------------
	// opcode on top, operand below
	assign op  = smOp_e'(fetchData_i[`SM_WORD_W-1:`SM_ARG_W]);
	assign arg = fetchData_i[`SM_ARG_W-1:0];

	// pc stays put through fetch and exec
	assign fetchAddr_o = pc;
	assign fetchSel_o  = (state == SeqFetch);
	assign busy_o      = (state != SeqIdle);

	// one-cycle pulse while executing emit
	assign event_o.valid = (state == SeqExec) && (op == OpEmit);
	assign event_o.arg   = arg;

	// ------------------------------
	// state machine
	// ------------------------------
	always_ff @(posedge ReadClockIn) begin
		if (reset_i) begin
			state   <= SeqIdle;
			pc      <= '0;
			waitCnt <= '0;
		end else if (ctrl_i.abort) begin
			// abort wins from any state
			state   <= SeqIdle;
		end else begin
			case (state)
				SeqIdle: begin
					if (ctrl_i.start) begin
						pc    <= ctrl_i.startPc;
						state <= SeqFetch;
					end
				end

				// ram registers the word here
				SeqFetch: begin
					state <= SeqExec;
				end

				SeqExec: begin
					case (op)
						OpJump: begin
							// low 10 bits, may land in bank 1
							pc    <= arg[`SM_ADDR_W-1:0];
							state <= SeqFetch;
						end
						OpWait: begin
							if (arg == '0) begin
								pc    <= pc + 1'b1;
								state <= SeqFetch;
							end else begin
								waitCnt <= arg;
								state   <= SeqWait;
							end
						end
						OpHalt: begin
							state <= SeqIdle;
						end
						// emit, nop and unused codes just advance
						default: begin
							pc    <= pc + 1'b1;
							state <= SeqFetch;
						end
					endcase
				end

				// n extra cycles
				SeqWait: begin
					waitCnt <= waitCnt - 1'b1;
					if (waitCnt == smArg_t'(1)) begin
						pc    <= pc + 1'b1;
						state <= SeqFetch;
					end
				end

				default: begin
					state <= SeqIdle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/smControlRegs.sv */
`default_nettype none
`include "sm_settings.svh"

module smControlRegs import smPkg::*; (
	input  wire            ReadClockIn,
	input  wire            reset_i,

	// host register port
	input  wire            regWrite_i,
	input  wire            regRead_i,
	input  wire [1:0]      regAddr_i,
	input  wire smReg_t    regData_i,

	// sequencer status and events
	input  wire            busy_i,
	input  wire smEvent_t  event_i,

	output smCtrl_t        ctrl_o,
	output smReg_t         regReadData_o
);

	// ------------------------------
	// register map
	// ------------------------------
	localparam logic [1:0] RegStartPc = 2'd0;
	localparam logic [1:0] RegControl = 2'd1;
	localparam logic [1:0] RegEvents  = 2'd2;
	localparam logic [1:0] RegStatus  = 2'd3;

	smAddr_t startPcQ;
	smReg_t  eventCount;
	logic    controlWrite;

	assign controlWrite = regWrite_i && (regAddr_i == RegControl);

	// start and abort are strobes, never stored
	assign ctrl_o.startPc = startPcQ;
	assign ctrl_o.start   = controlWrite && regData_i[0];
	assign ctrl_o.abort   = controlWrite && regData_i[1];

	// start address
	always_ff @(posedge ReadClockIn) begin
		if (reset_i) begin
			startPcQ <= '0;
		end else if (regWrite_i && (regAddr_i == RegStartPc)) begin
			startPcQ <= regData_i[`SM_ADDR_W-1:0];
		end
	end

	// event counter, cleared by a new run
	always_ff @(posedge ReadClockIn) begin
		if (reset_i) begin
			eventCount <= '0;
		end else if (ctrl_o.start) begin
			eventCount <= '0;
		end else if (event_i.valid) begin
			eventCount <= eventCount + 1'b1;
		end
	end

	// ------------------------------
	// readback
	// ------------------------------
	// control reads as zero
	always_ff @(posedge ReadClockIn) begin
		if (regRead_i) begin
			case (regAddr_i)
				RegStartPc: regReadData_o <= smReg_t'(startPcQ);
				RegControl: regReadData_o <= '0;
				RegEvents:  regReadData_o <= eventCount;
				RegStatus:  regReadData_o <= smReg_t'(busy_i);
				default:    regReadData_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/smHub.sv */
`default_nettype none
`include "sm_settings.svh"

module smHub import smPkg::*; (
	input  wire            ReadClockIn,
	input  wire            reset_i,

	// bank loading
	input  wire smWrite_t  loadWrite_i,
	input  wire smWrite_t  dataWrite_i,

	// host reads
	input  wire            hostReadSel_i,
	input  wire smAddr_t   hostReadAddr_i,
	output smWord_t        hostReadData_o,
	output logic           hostReadValid_o,

	// register port
	input  wire            regWrite_i,
	input  wire            regRead_i,
	input  wire [1:0]      regAddr_i,
	input  wire smReg_t    regData_i,
	output smReg_t         regReadData_o,

	// events to the sensor side
	output smEvent_t       event_o
);

	// ------------------------------
	// internal nets
	// ------------------------------
	smCtrl_t              ctrl;
	logic                 busy;
	smAddr_t              fetchAddr;
	logic                 fetchSel;

	// memory to banks
	smWord_t              bank0Data;
	smWord_t              bank1Data;
	logic                 bank0ReadSel;
	logic                 bank1ReadSel;
	logic [`SM_ADDR_W-2:0] readWord;
	smWrite_t             bank0Write;
	smWrite_t             bank1Write;

	// registers, counting events
	smControlRegs i_smControlRegs (
		.ReadClockIn   (ReadClockIn),
		.reset_i       (reset_i),
		.regWrite_i    (regWrite_i),
		.regRead_i     (regRead_i),
		.regAddr_i     (regAddr_i),
		.regData_i     (regData_i),
		.busy_i        (busy),
		.event_i       (event_o),
		.ctrl_o        (ctrl),
		.regReadData_o (regReadData_o)
	);

	// fetch data shares the host read path
	smSequencer i_smSequencer (
		.ReadClockIn (ReadClockIn),
		.reset_i     (reset_i),
		.ctrl_i      (ctrl),
		.fetchData_i (hostReadData_o),
		.fetchAddr_o (fetchAddr),
		.fetchSel_o  (fetchSel),
		.busy_o      (busy),
		.event_o     (event_o)
	);

	// ------------------------------
	// memory and banks
	// ------------------------------
	smMemory i_smMemory (
		.ReadClockIn     (ReadClockIn),
		.reset_i         (reset_i),
		.busy_i          (busy),
		.fetchAddr_i     (fetchAddr),
		.fetchSel_i      (fetchSel),
		.hostReadAddr_i  (hostReadAddr_i),
		.hostReadSel_i   (hostReadSel_i),
		.loadWrite_i     (loadWrite_i),
		.dataWrite_i     (dataWrite_i),
		.bank0Data_i     (bank0Data),
		.bank1Data_i     (bank1Data),
		.bank0ReadSel_o  (bank0ReadSel),
		.bank1ReadSel_o  (bank1ReadSel),
		.readWord_o      (readWord),
		.bank0Write_o    (bank0Write),
		.bank1Write_o    (bank1Write),
		.readData_o      (hostReadData_o),
		.hostReadValid_o (hostReadValid_o)
	);

	// bank 0, instructions
	smBankRam i_smBankRam0 (
		.ReadClockIn (ReadClockIn),
		.writeSel_i  (bank0Write.sel),
		.writeAddr_i (bank0Write.addr),
		.writeData_i (bank0Write.data),
		.readSel_i   (bank0ReadSel),
		.readWord_i  (readWord),
		.readData_o  (bank0Data)
	);

	// bank 1, mailbox data or overflow code
	smBankRam i_smBankRam1 (
		.ReadClockIn (ReadClockIn),
		.writeSel_i  (bank1Write.sel),
		.writeAddr_i (bank1Write.addr),
		.writeData_i (bank1Write.data),
		.readSel_i   (bank1ReadSel),
		.readWord_i  (readWord),
		.readData_o  (bank1Data)
	);

endmodule

`default_nettype wire

/* testbench/tbClockGen.sv */
`default_nettype none

module tbClockGen (
	output logic clock_o,
	output logic reset_o
);

	// 40 unit period
	localparam int HalfPeriod = 20;

	initial begin
		clock_o = 1'b0;
		forever begin
			#HalfPeriod clock_o = ~clock_o;
		end
	end

	// five cycles of reset, dropped on a falling edge
	initial begin
		reset_o = 1'b1;
		repeat (5) @(posedge clock_o);
		@(negedge clock_o);
		reset_o = 1'b0;
	end

endmodule

`default_nettype wire

/* testbench/tbSmHub.sv */
`default_nettype none

module tbSmHub import smPkg::*; ();

	logic     ReadClockIn;
	logic     reset;
	smWrite_t loadWrite;
	smWrite_t dataWrite;
	logic     hostReadSel;
	smAddr_t  hostReadAddr;
	smWord_t  hostReadData;
	logic     hostReadValid;
	logic     regWrite;
	logic     regRead;
	logic [1:0] regAddr;
	smReg_t   regData;
	smReg_t   regReadData;
	smEvent_t evOut;

	// model of both banks indexed by bank then word
	smWord_t     shadow [2][512];
	smArg_t      expArgs [$];
	smArg_t      evArgs [$];
	int          evTimes [$];
	int          cycle = 0;
	int          checks = 0;
	int          errors = 0;
	int          timeouts = 0;
	logic [31:0] lfsr = 32'hc3e51ed9;

	tbClockGen clockGen (.clock_o(ReadClockIn), .reset_o(reset));

	smHub i_smHub (
		.ReadClockIn     (ReadClockIn),
		.reset_i         (reset),
		.loadWrite_i     (loadWrite),
		.dataWrite_i     (dataWrite),
		.hostReadSel_i   (hostReadSel),
		.hostReadAddr_i  (hostReadAddr),
		.hostReadData_o  (hostReadData),
		.hostReadValid_o (hostReadValid),
		.regWrite_i      (regWrite),
		.regRead_i       (regRead),
		.regAddr_i       (regAddr),
		.regData_i       (regData),
		.regReadData_o   (regReadData),
		.event_o         (evOut)
	);

	// ------------------------------
	// event monitor
	// ------------------------------
	always @(posedge ReadClockIn) cycle <= cycle + 1;

	// record each event arg and the cycle it showed up in
	always @(negedge ReadClockIn) begin
		if (!reset && evOut.valid) begin
			evArgs.push_back(evOut.arg);
			evTimes.push_back(cycle);
		end
	end

	// galois lfsr stepped once per bit
	function automatic logic [31:0] randomBits(input int width);
		logic [31:0] value;
		int          i;
		value = '0;
		for (i = 0; i < width; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return value;
	endfunction

	// opcode above the operand
	function automatic smWord_t encode(input smOp_e op, input smArg_t arg);
		return {op, arg};
	endfunction

	task automatic expectEqual(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// ------------------------------
	// bus helpers
	// ------------------------------
	// load port for bank 0 and data port for bank 1
	task automatic writeHalf(input bit bank, input smWAddr_t addr, input smHalf_t data);
		@(negedge ReadClockIn);
		if (bank) begin
			dataWrite = '{1'b1, addr, data};
		end else begin
			loadWrite = '{1'b1, addr, data};
		end
		// even address is the low half and odd the high half
		if (addr[0]) begin
			shadow[bank][addr[9:1]][17:9] = data;
		end else begin
			shadow[bank][addr[9:1]][8:0] = data;
		end
		@(negedge ReadClockIn);
		loadWrite.sel = 1'b0;
		dataWrite.sel = 1'b0;
	endtask

	task automatic storeWord(input bit bank, input logic [8:0] word, input smWord_t value);
		writeHalf(bank, {word, 1'b0}, value[8:0]);
		writeHalf(bank, {word, 1'b1}, value[17:9]);
	endtask

	// live set means the read must be answered
	task automatic hostRead(input smAddr_t addr, input smWord_t expected, input bit live);
		@(negedge ReadClockIn);
		hostReadSel = 1'b1;
		hostReadAddr = addr;
		@(negedge ReadClockIn);
		expectEqual("hostReadValid_o", hostReadValid, live);
		if (live) begin
			expectEqual("hostReadData_o", hostReadData, expected);
		end
		hostReadSel = 1'b0;
		// valid lasts one cycle only
		@(negedge ReadClockIn);
		expectEqual("hostReadValid_o", hostReadValid, 1'b0);
	endtask

	task automatic setReg(input logic [1:0] addr, input smReg_t data);
		@(negedge ReadClockIn);
		regWrite = 1'b1;
		regAddr = addr;
		regData = data;
		@(negedge ReadClockIn);
		regWrite = 1'b0;
	endtask

	task automatic getReg(input logic [1:0] addr, output smReg_t data);
		@(negedge ReadClockIn);
		regRead = 1'b1;
		regAddr = addr;
		@(negedge ReadClockIn);
		regRead = 1'b0;
		data = regReadData;
	endtask

	// ------------------------------
	// run control
	// ------------------------------
	task automatic startRun(input smAddr_t pc);
		evArgs.delete();
		evTimes.delete();
		setReg(2'd0, smReg_t'(pc));
		setReg(2'd1, 16'h0001);
	endtask

	task automatic waitEvents(input int count, input int limit);
		int waited;
		waited = 0;
		// checked on rising edges away from the monitor
		while (evArgs.size() < count && waited < limit) begin
			@(posedge ReadClockIn);
			waited++;
		end
		if (evArgs.size() < count) begin
			timeouts++;
			$display("timeout: expected %0d events, only %0d arrived", count, evArgs.size());
		end
	endtask

	// polls the status register until busy clears
	task automatic waitIdle(input int limit);
		smReg_t status;
		int     polls;
		status = '1;
		polls = 0;
		while (status[0] && polls < limit) begin
			getReg(2'd3, status);
			polls++;
		end
		if (status[0]) begin
			timeouts++;
			$display("timeout: sequencer still busy after %0d status polls", limit);
		end
	endtask

	task automatic checkArgs();
		int i;
		expectEqual("event_o.valid count", evArgs.size(), expArgs.size());
		for (i = 0; i < expArgs.size() && i < evArgs.size(); i++) begin
			expectEqual("event_o.arg", evArgs[i], expArgs[i]);
		end
	endtask

	initial begin
		int         k;
		int         n;
		int         waited;
		logic [8:0] word;
		smArg_t     a;
		smReg_t     value;
		loadWrite = '0;
		dataWrite = '0;
		hostReadSel = 1'b0;
		hostReadAddr = '0;
		regWrite = 1'b0;
		regRead = 1'b0;
		regAddr = '0;
		regData = '0;
		waited = 0;
		while (reset && waited < 20) begin
			@(negedge ReadClockIn);
			waited++;
		end
		if (reset) begin
			timeouts++;
			$display("timeout: reset was never released");
		end
		// quiet outputs out of reset
		expectEqual("hostReadValid_o", hostReadValid, 1'b0);
		expectEqual("event_o.valid", evOut.valid, 1'b0);
		getReg(2'd3, value);
		expectEqual("regReadData_o busy", value[0], 1'b0);

		// same word in both banks read back while idle
		for (k = 0; k < 8; k++) begin
			word = 9'(randomBits(9));
			writeHalf(1'b0, {word, 1'b0}, smHalf_t'(randomBits(9)));
			writeHalf(1'b0, {word, 1'b1}, smHalf_t'(randomBits(9)));
			writeHalf(1'b1, {word, 1'b1}, smHalf_t'(randomBits(9)));
			writeHalf(1'b1, {word, 1'b0}, smHalf_t'(randomBits(9)));
			hostRead({1'b0, word}, shadow[0][word], 1'b1);
			hostRead({1'b1, word}, shadow[1][word], 1'b1);
		end

		// straight emits then halt
		expArgs.delete();
		for (k = 0; k < 4; k++) begin
			a = smArg_t'(randomBits(15));
			expArgs.push_back(a);
			storeWord(1'b0, 9'(k), encode(OpEmit, a));
		end
		storeWord(1'b0, 9'd4, encode(OpHalt, '0));
		startRun(10'd0);
		waitEvents(4, 40);
		waitIdle(10);
		checkArgs();

		// jump into bank 1 with code loaded through the data port
		expArgs.delete();
		a = smArg_t'(randomBits(15));
		expArgs.push_back(a);
		storeWord(1'b0, 9'd16, encode(OpEmit, a));
		storeWord(1'b0, 9'd17, encode(OpJump, 15'd552));
		storeWord(1'b1, 9'd40, encode(OpEmit, smArg_t'(randomBits(15))));
		storeWord(1'b1, 9'd41, encode(OpEmit, smArg_t'(randomBits(15))));
		storeWord(1'b1, 9'd42, encode(OpHalt, '0));
		expArgs.push_back(shadow[1][40][14:0]);
		expArgs.push_back(shadow[1][41][14:0]);
		startRun(10'd16);
		waitEvents(3, 40);
		waitIdle(10);
		checkArgs();

		// second emit lands 4+n cycles after the first
		for (k = 0; k < 4; k++) begin
			n = int'(randomBits(3)) + 1;
			expArgs.delete();
			expArgs.push_back(smArg_t'(randomBits(15)));
			expArgs.push_back(smArg_t'(randomBits(15)));
			storeWord(1'b0, 9'd64, encode(OpEmit, expArgs[0]));
			storeWord(1'b0, 9'd65, encode(OpWait, smArg_t'(n)));
			storeWord(1'b0, 9'd66, encode(OpEmit, expArgs[1]));
			storeWord(1'b0, 9'd67, encode(OpHalt, '0));
			startRun(10'd64);
			waitEvents(2, 30 + n);
			waitIdle(10);
			checkArgs();
			if (evTimes.size() >= 2) begin
				expectEqual("event_o.valid gap", evTimes[1] - evTimes[0], 4 + n);
			end
		end

		// host read during a run is dropped
		expArgs.delete();
		for (k = 0; k < 3; k++) begin
			expArgs.push_back(smArg_t'(randomBits(15)));
		end
		storeWord(1'b0, 9'd100, encode(OpEmit, expArgs[0]));
		storeWord(1'b0, 9'd101, encode(OpWait, 15'd20));
		storeWord(1'b0, 9'd102, encode(OpEmit, expArgs[1]));
		storeWord(1'b0, 9'd103, encode(OpEmit, expArgs[2]));
		storeWord(1'b0, 9'd104, encode(OpHalt, '0));
		startRun(10'd100);
		waitEvents(1, 10);
		hostRead(10'd100, '0, 1'b0);
		waitEvents(3, 60);
		waitIdle(10);
		checkArgs();
		getReg(2'd2, value);
		expectEqual("regReadData_o event count", value, 16'd3);
		getReg(2'd3, value);
		expectEqual("regReadData_o busy", value[0], 1'b0);

		// abort in the middle of a long wait
		expArgs.delete();
		expArgs.push_back(smArg_t'(randomBits(15)));
		storeWord(1'b0, 9'd120, encode(OpEmit, expArgs[0]));
		storeWord(1'b0, 9'd121, encode(OpWait, 15'd2000));
		storeWord(1'b0, 9'd122, encode(OpEmit, smArg_t'(randomBits(15))));
		storeWord(1'b0, 9'd123, encode(OpHalt, '0));
		startRun(10'd120);
		waitEvents(1, 10);
		repeat (10) @(negedge ReadClockIn);
		setReg(2'd1, 16'h0002);
		waitIdle(4);
		// past the point where the second emit would run
		repeat (2100) @(negedge ReadClockIn);
		checkArgs();
		getReg(2'd2, value);
		expectEqual("regReadData_o event count", value, 16'd1);

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/smPkg.sv
logic/smBankRam.sv
logic/smMemory.sv
logic/smSequencer.sv
logic/smControlRegs.sv
logic/smHub.sv
testbench/tbClockGen.sv
testbench/tbSmHub.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tbSmHub -f src.f \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/VtbSmHub > sim.log 2>&1
cat sim.log

grep -q "Test failures found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
